/* hw/usb_pkg.sv */
package usb_pkg;

  // Packet identifiers as they appear on the bus
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } usb_pid_t;

  // Decoded token, valid together with the token strobe
  typedef struct packed {
    logic [6:0] addr;
    logic [3:0] endp;
    usb_pid_t   pid;
  } usb_token_t;

  // Byte beat from the packet decoder
  // pid carries the PID of the packet the byte belongs to
  typedef struct packed {
    logic       valid;
    logic       keep;
    logic       last;
    usb_pid_t   pid;
    logic [7:0] data;
  } usb_rx_beat_t;

  // Byte beat towards the packet encoder
  typedef struct packed {
    logic       valid;
    logic       last;
    logic [7:0] data;
  } usb_tx_beat_t;

endpackage

/* hw/ctrl_pkg.sv */
package ctrl_pkg;

  // Number of bytes in the SETUP data packet
  localparam int SETUP_BYTES = 8;

  // Highest configuration value the device accepts
  localparam logic [7:0] MAX_CONFIG = 8'd1;

  // Bus powered, no remote wakeup
  localparam logic [15:0] STATUS_REPLY = 16'h0000;

  // SETUP packet, first byte on the bus at the top
  // Multi-byte fields hold their value, low byte arrives first
  typedef struct packed {
    logic [7:0]  rtype;
    logic [7:0]  request;
    logic [15:0] value;
    logic [15:0] index;
    logic [15:0] length;
  } setup_pkt_t;

  // Stages of a control transfer
  typedef enum logic [1:0] {
    STAGE_IDLE,
    STAGE_SETUP,
    STAGE_DATA,
    STAGE_STATUS
  } ctrl_stage_t;

  // Standard request codes handled here
  typedef enum logic [7:0] {
    REQ_GET_STATUS        = 8'd0,
    REQ_SET_ADDRESS       = 8'd5,
    REQ_GET_CONFIGURATION = 8'd8,
    REQ_SET_CONFIGURATION = 8'd9
  } std_req_t;

  // Operation handed to the execute and result blocks
  typedef enum logic [2:0] {
    OP_NONE,
    OP_GET_STATUS,
    OP_GET_CONFIG,
    OP_SET_ADDRESS,
    OP_SET_CONFIG,
    OP_UNSUPPORTED
  } req_op_t;

endpackage

/* hw/ctrl_stage_fsm.sv */
module ctrl_stage_fsm (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  tok_recv_i,
  input  usb_pkg::usb_token_t   tok_i,
  input  usb_pkg::usb_rx_beat_t rx_i,
  input  logic                  hsk_sent_i,
  input  logic                  hsk_recv_i,
  input  logic                  timeout_i,
  input  logic [6:0]            usb_addr_i,
  input  logic                  req_error_i,
  output logic                  select_o,
  output logic                  start_o,
  output logic                  parity_o,
  output logic                  finish_o,
  output ctrl_pkg::setup_pkt_t  setup_o,
  output logic                  req_start_o
);
  import usb_pkg::*;
  import ctrl_pkg::*;

  ctrl_stage_t stage_q;
  logic        start_q;
  logic        finish_q;
  logic        parity_q;
  logic        req_start_q;
  logic [2:0]  byte_cnt_q;
  logic        setup_full_q;
  setup_pkt_t  setup_q;
  logic        open_w;
  logic        byte_w;
  logic        end_w;

  // SETUP token for this device on endpoint 0, only between cycles
  assign open_w = stage_q == STAGE_IDLE && tok_recv_i && tok_i.pid == PID_SETUP &&
                  tok_i.addr == usb_addr_i && tok_i.endp == 4'h0;

  // Accepted SETUP data byte
  assign byte_w = stage_q == STAGE_SETUP && !setup_full_q && rx_i.valid &&
                  rx_i.keep && rx_i.pid == PID_DATA0;

  // Any handshake or timeout closes the status stage
  assign end_w = stage_q == STAGE_STATUS && (hsk_sent_i || hsk_recv_i || timeout_i);

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_q <= STAGE_IDLE;
    end else if (req_error_i) begin
      // Stalled request drops the cycle, no finish pulse
      stage_q <= STAGE_IDLE;
    end else begin
      case (stage_q)
        STAGE_IDLE: begin
          if (open_w) begin
            stage_q <= STAGE_SETUP;
          end
        end
        STAGE_SETUP: begin
          // OUT data is not forwarded, so set requests skip the data stage
          if (hsk_sent_i) begin
            if (setup_q.length == 16'h0000 || !setup_q.rtype[7]) begin
              stage_q <= STAGE_STATUS;
            end else begin
              stage_q <= STAGE_DATA;
            end
          end
        end
        STAGE_DATA: begin
          if (hsk_recv_i) begin
            stage_q <= STAGE_STATUS;
          end else if (timeout_i) begin
            stage_q <= STAGE_IDLE;
          end
        end
        STAGE_STATUS: begin
          if (end_w) begin
            stage_q <= STAGE_IDLE;
          end
        end
        default: stage_q <= STAGE_IDLE;
      endcase
    end
  end

  // Data toggle, DATA1 after the SETUP ack and always in status
  always_ff @(posedge clock) begin
    if (reset || req_error_i) begin
      parity_q <= 1'b0;
    end else begin
      case (stage_q)
        STAGE_IDLE:   parity_q <= 1'b0;
        STAGE_SETUP:  if (hsk_sent_i) parity_q <= 1'b1;
        STAGE_DATA:   if (hsk_recv_i) parity_q <= ~parity_q;
        STAGE_STATUS: parity_q <= 1'b1;
        default:      parity_q <= 1'b0;
      endcase
    end
  end

  // Byte counter restarts with every cycle
  always_ff @(posedge clock) begin
    if (reset || open_w) begin
      byte_cnt_q   <= 3'd0;
      setup_full_q <= 1'b0;
    end else if (byte_w) begin
      if (byte_cnt_q == 3'(SETUP_BYTES - 1)) begin
        setup_full_q <= 1'b1;
      end else begin
        byte_cnt_q <= byte_cnt_q + 3'd1;
      end
    end
  end

  // Bytes land in their field, low byte first for 16-bit fields
  always_ff @(posedge clock) begin
    if (byte_w) begin
      case (byte_cnt_q)
        3'd0: setup_q.rtype         <= rx_i.data;
        3'd1: setup_q.request       <= rx_i.data;
        3'd2: setup_q.value[7:0]    <= rx_i.data;
        3'd3: setup_q.value[15:8]   <= rx_i.data;
        3'd4: setup_q.index[7:0]    <= rx_i.data;
        3'd5: setup_q.index[15:8]   <= rx_i.data;
        3'd6: setup_q.length[7:0]   <= rx_i.data;
        default: setup_q.length[15:8] <= rx_i.data;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      start_q     <= 1'b0;
      finish_q    <= 1'b0;
      req_start_q <= 1'b0;
    end else begin
      start_q     <= open_w;
      finish_q    <= end_w;
      // One cycle after the last SETUP byte
      req_start_q <= byte_w && byte_cnt_q == 3'(SETUP_BYTES - 1);
    end
  end

  assign select_o    = stage_q != STAGE_IDLE;
  assign start_o     = start_q;
  assign parity_o    = parity_q;
  assign finish_o    = finish_q;
  assign setup_o     = setup_q;
  assign req_start_o = req_start_q;

endmodule

/* hw/ctrl_req_decode.sv */
module ctrl_req_decode (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req_start_i,
  input  ctrl_pkg::setup_pkt_t setup_i,
  output logic                 op_valid_o,
  output ctrl_pkg::req_op_t    op_o,
  output logic [15:0]          arg_o,
  output logic [1:0]           reply_len_o
);
  import ctrl_pkg::*;

  req_op_t     op_w;
  logic [1:0]  nat_len_w;
  logic        std_w;
  logic        dir_in_w;
  logic        op_valid_q;
  req_op_t     op_q;
  logic [15:0] arg_q;
  logic [1:0]  len_q;

  // Standard type with device recipient, either direction
  assign std_w    = setup_i.rtype[6:0] == 7'h00;
  assign dir_in_w = setup_i.rtype[7];

  always_comb begin
    op_w      = OP_UNSUPPORTED;
    nat_len_w = 2'd0;
    if (std_w) begin
      case (setup_i.request)
        REQ_GET_STATUS: begin
          op_w      = dir_in_w ? OP_GET_STATUS : OP_UNSUPPORTED;
          nat_len_w = 2'd2;
        end
        REQ_GET_CONFIGURATION: begin
          op_w      = dir_in_w ? OP_GET_CONFIG : OP_UNSUPPORTED;
          nat_len_w = 2'd1;
        end
        REQ_SET_ADDRESS:       op_w = dir_in_w ? OP_UNSUPPORTED : OP_SET_ADDRESS;
        REQ_SET_CONFIGURATION: op_w = dir_in_w ? OP_UNSUPPORTED : OP_SET_CONFIG;
        default:               op_w = OP_UNSUPPORTED;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      op_valid_q <= 1'b0;
      op_q       <= OP_NONE;
    end else begin
      op_valid_q <= req_start_i;
      if (req_start_i) begin
        op_q <= op_w;
      end
    end
  end

  // Host may ask for less than the natural reply
  always_ff @(posedge clock) begin
    if (req_start_i) begin
      arg_q <= setup_i.value;
      if (setup_i.length < {14'd0, nat_len_w}) begin
        len_q <= setup_i.length[1:0];
      end else begin
        len_q <= nat_len_w;
      end
    end
  end

  assign op_valid_o  = op_valid_q;
  assign op_o        = op_q;
  assign arg_o       = arg_q;
  assign reply_len_o = len_q;

endmodule

/* hw/ctrl_req_execute.sv */
module ctrl_req_execute (
  input  logic              clock,
  input  logic              reset,
  input  logic              op_valid_i,
  input  ctrl_pkg::req_op_t op_i,
  input  logic [15:0]       arg_i,
  input  logic              finish_i,
  output logic [6:0]        usb_addr_o,
  output logic [7:0]        config_o,
  output logic              configured_o,
  output logic              req_error_o
);
  import ctrl_pkg::*;

  logic [6:0] addr_q;
  logic [6:0] pend_addr_q;
  logic       pend_valid_q;
  logic [7:0] config_q;
  logic       error_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      addr_q       <= 7'd0;
      pend_valid_q <= 1'b0;
      config_q     <= 8'd0;
      error_q      <= 1'b0;
    end else begin
      error_q <= 1'b0;
      if (op_valid_i) begin
        // A new request drops any address left from an aborted cycle
        pend_valid_q <= 1'b0;
        case (op_i)
          OP_SET_CONFIG: begin
            if (arg_i <= {8'h00, MAX_CONFIG}) begin
              config_q <= arg_i[7:0];
            end else begin
              error_q <= 1'b1;
            end
          end
          OP_SET_ADDRESS: begin
            // Address only takes effect after the status stage
            if (arg_i[15:7] == 9'd0) begin
              pend_addr_q  <= arg_i[6:0];
              pend_valid_q <= 1'b1;
            end else begin
              error_q <= 1'b1;
            end
          end
          OP_UNSUPPORTED: error_q <= 1'b1;
          default: error_q <= 1'b0;
        endcase
      end else if (finish_i && pend_valid_q) begin
        addr_q       <= pend_addr_q;
        pend_valid_q <= 1'b0;
      end
    end
  end

  assign usb_addr_o   = addr_q;
  assign config_o     = config_q;
  assign configured_o = config_q != 8'd0;
  assign req_error_o  = error_q;

endmodule

/* hw/ctrl_req_result.sv */
module ctrl_req_result (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  op_valid_i,
  input  ctrl_pkg::req_op_t     op_i,
  input  logic [1:0]            reply_len_i,
  input  logic [7:0]            config_i,
  input  logic                  tx_ready_i,
  input  logic                  abort_i,
  output usb_pkg::usb_tx_beat_t tx_o
);
  import ctrl_pkg::*;

  logic       valid_q;
  logic [1:0] left_q;
  logic [7:0] head_q;
  logic       load_w;
  logic       take_w;

  // Only GET requests with a non-zero reply produce beats
  assign load_w = op_valid_i && (op_i == OP_GET_STATUS || op_i == OP_GET_CONFIG) &&
                  reply_len_i != 2'd0;
  assign take_w = valid_q && tx_ready_i;

  always_ff @(posedge clock) begin
    if (reset || abort_i) begin
      valid_q <= 1'b0;
      left_q  <= 2'd0;
    end else if (load_w) begin
      valid_q <= 1'b1;
      left_q  <= reply_len_i;
    end else if (take_w) begin
      if (left_q == 2'd1) begin
        valid_q <= 1'b0;
      end
      left_q <= left_q - 2'd1;
    end
  end

  // Reply bytes, low byte of the status word goes first
  always_ff @(posedge clock) begin
    if (load_w) begin
      head_q <= op_i == OP_GET_STATUS ? STATUS_REPLY[7:0] : config_i;
    end else if (take_w) begin
      // Only the status reply has a second byte
      head_q <= STATUS_REPLY[15:8];
    end
  end

  assign tx_o.valid = valid_q;
  assign tx_o.last  = left_q == 2'd1;
  assign tx_o.data  = head_q;

endmodule

/* hw/ctrl_endpoint0.sv */
module ctrl_endpoint0 (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  tok_recv_i,
  input  usb_pkg::usb_token_t   tok_i,
  input  usb_pkg::usb_rx_beat_t rx_i,
  input  logic                  hsk_sent_i,
  input  logic                  hsk_recv_i,
  input  logic                  timeout_i,
  input  logic                  tx_ready_i,
  output logic                  select_o,
  output logic                  start_o,
  output logic                  parity_o,
  output logic                  finish_o,
  output logic                  stall_o,
  output usb_pkg::usb_tx_beat_t tx_o,
  output logic [6:0]            usb_addr_o,
  output logic                  configured_o
);
  import ctrl_pkg::*;

  setup_pkt_t  setup;
  logic        req_start;
  logic        op_valid;
  req_op_t     op;
  logic [15:0] arg;
  logic [1:0]  reply_len;
  logic [7:0]  config_byte;
  logic        req_error;

  // Stage sequencing and SETUP capture
  ctrl_stage_fsm stage_i (
    .clock       (clock),
    .reset       (reset),
    .tok_recv_i  (tok_recv_i),
    .tok_i       (tok_i),
    .rx_i        (rx_i),
    .hsk_sent_i  (hsk_sent_i),
    .hsk_recv_i  (hsk_recv_i),
    .timeout_i   (timeout_i),
    .usb_addr_i  (usb_addr_o),
    .req_error_i (req_error),
    .select_o    (select_o),
    .start_o     (start_o),
    .parity_o    (parity_o),
    .finish_o    (finish_o),
    .setup_o     (setup),
    .req_start_o (req_start)
  );

  ctrl_req_decode decode_i (
    .clock       (clock),
    .reset       (reset),
    .req_start_i (req_start),
    .setup_i     (setup),
    .op_valid_o  (op_valid),
    .op_o        (op),
    .arg_o       (arg),
    .reply_len_o (reply_len)
  );

  ctrl_req_execute execute_i (
    .clock        (clock),
    .reset        (reset),
    .op_valid_i   (op_valid),
    .op_i         (op),
    .arg_i        (arg),
    .finish_i     (finish_o),
    .usb_addr_o   (usb_addr_o),
    .config_o     (config_byte),
    .configured_o (configured_o),
    .req_error_o  (req_error)
  );

  // Reply is dropped once the cycle is no longer selected
  ctrl_req_result result_i (
    .clock       (clock),
    .reset       (reset),
    .op_valid_i  (op_valid),
    .op_i        (op),
    .reply_len_i (reply_len),
    .config_i    (config_byte),
    .tx_ready_i  (tx_ready_i),
    .abort_i     (~select_o),
    .tx_o        (tx_o)
  );

  assign stall_o = req_error;

endmodule

/* test/ctrl_endpoint0_tb.sv */
module ctrl_endpoint0_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import usb_pkg::*;
  import ctrl_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_TESTS  = 5;
  // Cycles allowed for a reply under random back-pressure
  localparam int REPLY_WAIT = 64;

  // Handshake kinds
  localparam int HSK_SENT    = 0;
  localparam int HSK_RECV    = 1;
  localparam int HSK_TIMEOUT = 2;

  logic         clock;
  logic         reset;
  logic         tok_recv;
  usb_token_t   tok;
  usb_rx_beat_t rx;
  logic         hsk_sent;
  logic         hsk_recv;
  logic         timeout;
  logic         tx_ready;
  logic         select;
  logic         start;
  logic         parity;
  logic         finish;
  logic         stall;
  usb_tx_beat_t tx;
  logic [6:0]   usb_addr;
  logic         configured;

  // Reference model of the device state
  logic [6:0] exp_addr;
  logic [7:0] exp_config;

  integer seed;
  int     checks;
  int     errors;

  ctrl_endpoint0 dut_i (
    .clock        (clock),
    .reset        (reset),
    .tok_recv_i   (tok_recv),
    .tok_i        (tok),
    .rx_i         (rx),
    .hsk_sent_i   (hsk_sent),
    .hsk_recv_i   (hsk_recv),
    .timeout_i    (timeout),
    .tx_ready_i   (tx_ready),
    .select_o     (select),
    .start_o      (start),
    .parity_o     (parity),
    .finish_o     (finish),
    .stall_o      (stall),
    .tx_o         (tx),
    .usb_addr_o   (usb_addr),
    .configured_o (configured)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Inputs change and outputs are sampled 5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clock);
    #5;
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input logic [6:0] got, input logic [6:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is 0x%h, expected 0x%h", $time, what, got, exp);
    end
  endtask

  task automatic check_beat(input string what, input usb_tx_beat_t got,
                            input usb_tx_beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is valid=%b last=%b data=0x%h", $time, what,
               got.valid, got.last, got.data);
      $display("  expected valid=%b last=%b data=0x%h", exp.valid, exp.last, exp.data);
    end
  endtask

  // configured_o follows a non-zero configuration value
  task automatic check_config(input string what, input logic got, input logic [7:0] cfg);
    checks++;
    if (got !== (cfg != 8'd0)) begin
      errors++;
      $display("mismatch at %0t: %s is %b for configuration %0d", $time, what, got, cfg);
    end
  endtask

  function automatic setup_pkt_t make_setup(input logic [7:0] rtype, input logic [7:0] request,
                                            input logic [15:0] value, input logic [15:0] length);
    setup_pkt_t pkt;
    pkt.rtype   = rtype;
    pkt.request = request;
    pkt.value   = value;
    pkt.index   = 16'h0000;
    pkt.length  = length;
    return pkt;
  endfunction

  task automatic send_token(input logic [6:0] addr, input logic [3:0] endp, input usb_pid_t pid);
    tok.addr = addr;
    tok.endp = endp;
    tok.pid  = pid;
    tok_recv = 1'b1;
    next_cycle();
    tok_recv = 1'b0;
  endtask

  // Eight DATA0 beats, 16-bit fields low byte first
  task automatic send_setup(input setup_pkt_t pkt);
    logic [7:0] setup_bytes [SETUP_BYTES];
    setup_bytes[0] = pkt.rtype;
    setup_bytes[1] = pkt.request;
    setup_bytes[2] = pkt.value[7:0];
    setup_bytes[3] = pkt.value[15:8];
    setup_bytes[4] = pkt.index[7:0];
    setup_bytes[5] = pkt.index[15:8];
    setup_bytes[6] = pkt.length[7:0];
    setup_bytes[7] = pkt.length[15:8];
    for (int i = 0; i < SETUP_BYTES; i++) begin
      rx.valid = 1'b1;
      rx.keep  = 1'b1;
      rx.last  = i == SETUP_BYTES - 1;
      rx.pid   = PID_DATA0;
      rx.data  = setup_bytes[i];
      next_cycle();
    end
    rx.valid = 1'b0;
    rx.keep  = 1'b0;
    rx.last  = 1'b0;
  endtask

  task automatic send_hsk(input int kind);
    hsk_sent = kind == HSK_SENT;
    hsk_recv = kind == HSK_RECV;
    timeout  = kind == HSK_TIMEOUT;
    next_cycle();
    hsk_sent = 1'b0;
    hsk_recv = 1'b0;
    timeout  = 1'b0;
  endtask

  // SETUP token to the current address, start_o is a single pulse
  task automatic open_cycle();
    send_token(exp_addr, 4'h0, PID_SETUP);
    check_bit("start_o after SETUP token", start, 1'b1);
    check_bit("select_o after SETUP token", select, 1'b1);
    check_bit("parity_o in setup stage", parity, 1'b0);
    next_cycle();
    check_bit("start_o one cycle later", start, 1'b0);
  endtask

  // Random tx_ready, a beat moves when valid and ready meet at an edge
  task automatic collect_reply(input int n, input logic [7:0] b0, input logic [7:0] b1);
    usb_tx_beat_t exp;
    int           got_n;
    int           waited;
    logic         done;
    got_n  = 0;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < REPLY_WAIT) begin
      tx_ready = ($random(seed) & 3) != 0;
      if (tx.valid && tx_ready) begin
        exp.valid = 1'b1;
        exp.last  = got_n == n - 1;
        exp.data  = got_n == 0 ? b0 : b1;
        check_beat($sformatf("reply beat %0d", got_n), tx, exp);
        got_n++;
        done = tx.last || got_n >= n;
      end
      next_cycle();
      waited++;
    end
    tx_ready = 1'b0;
    if (got_n < n) begin
      errors++;
      $display("Reply incomplete at %0t: %0d of %0d beats arrived", $time, got_n, n);
    end
    check_bit("tx_o.valid after the reply", tx.valid, 1'b0);
  endtask

  // Full IN control transfer with the data toggle at each stage
  task automatic run_in_request(input setup_pkt_t pkt, input int n,
                                input logic [7:0] b0, input logic [7:0] b1);
    open_cycle();
    send_setup(pkt);
    send_hsk(HSK_SENT);
    check_bit("select_o in data stage", select, 1'b1);
    check_bit("parity_o at start of data stage", parity, 1'b1);
    collect_reply(n, b0, b1);
    send_hsk(HSK_RECV);
    check_bit("parity_o after data ACK", parity, 1'b0);
    next_cycle();
    check_bit("parity_o in status stage", parity, 1'b1);
    send_hsk(HSK_SENT);
    check_bit("finish_o after status ACK", finish, 1'b1);
    check_bit("select_o after status ACK", select, 1'b0);
    next_cycle();
    check_bit("finish_o one cycle later", finish, 1'b0);
  endtask

  // Set request without data stage, configuration moves two cycles after req_start
  task automatic run_out_request(input setup_pkt_t pkt, input logic [7:0] new_config);
    open_cycle();
    send_setup(pkt);
    next_cycle();
    check_config("configured_o one cycle after req_start", configured, exp_config);
    next_cycle();
    exp_config = new_config;
    check_config("configured_o two cycles after req_start", configured, exp_config);
    check_bit("stall_o on accepted request", stall, 1'b0);
    check_addr("usb_addr_o in setup stage", usb_addr, exp_addr);
    send_hsk(HSK_SENT);
    check_bit("select_o in status stage", select, 1'b1);
    check_bit("parity_o in status stage", parity, 1'b1);
    send_hsk(HSK_RECV);
    check_bit("finish_o after status ACK", finish, 1'b1);
    check_bit("select_o after status ACK", select, 1'b0);
    check_addr("usb_addr_o on finish_o", usb_addr, exp_addr);
    next_cycle();
    check_bit("finish_o one cycle later", finish, 1'b0);
  endtask

  // Stall three cycles after the eighth byte, then the cycle is dropped
  task automatic stall_request(input setup_pkt_t pkt);
    open_cycle();
    send_setup(pkt);
    next_cycle();
    check_bit("stall_o before decode result", stall, 1'b0);
    next_cycle();
    check_bit("stall_o on rejected request", stall, 1'b1);
    check_config("configured_o on stall", configured, exp_config);
    next_cycle();
    check_bit("stall_o one cycle later", stall, 1'b0);
    check_bit("select_o after stall", select, 1'b0);
    check_bit("finish_o after stall", finish, 1'b0);
    for (int i = 0; i < 8; i++) begin
      check_bit("tx_o.valid after stall", tx.valid, 1'b0);
      next_cycle();
    end
  endtask

  task automatic test_reset_state();
    check_addr("usb_addr_o after reset", usb_addr, 7'h00);
    check_config("configured_o after reset", configured, 8'd0);
    check_bit("select_o after reset", select, 1'b0);
    check_bit("start_o after reset", start, 1'b0);
    check_bit("finish_o after reset", finish, 1'b0);
    check_bit("stall_o after reset", stall, 1'b0);
    check_bit("tx_o.valid after reset", tx.valid, 1'b0);
    // Wrong address, wrong endpoint, wrong token
    send_token(7'h05, 4'h0, PID_SETUP);
    check_bit("start_o for other address", start, 1'b0);
    send_token(7'h00, 4'h1, PID_SETUP);
    check_bit("start_o for other endpoint", start, 1'b0);
    send_token(7'h00, 4'h0, PID_OUT);
    check_bit("start_o for OUT token", start, 1'b0);
    check_bit("select_o with no cycle", select, 1'b0);
  endtask

  task automatic test_set_address();
    run_out_request(make_setup(8'h00, REQ_SET_ADDRESS, 16'h002A, 16'h0000), exp_config);
    exp_addr = 7'h2A;
    check_addr("usb_addr_o one cycle after finish_o", usb_addr, exp_addr);
    send_token(7'h00, 4'h0, PID_SETUP);
    check_bit("start_o for old address", start, 1'b0);
  endtask

  task automatic test_set_config();
    run_out_request(make_setup(8'h00, REQ_SET_CONFIGURATION, 16'h0001, 16'h0000), 8'd1);
    stall_request(make_setup(8'h00, REQ_SET_CONFIGURATION, 16'h0005, 16'h0000));
  endtask

  task automatic test_get_replies();
    run_in_request(make_setup(8'h80, REQ_GET_CONFIGURATION, 16'h0000, 16'h0001), 1,
                   exp_config, 8'h00);
    // Status word 0x0000, low byte first
    run_in_request(make_setup(8'h80, REQ_GET_STATUS, 16'h0000, 16'h0002), 2, 8'h00, 8'h00);
    run_in_request(make_setup(8'h80, REQ_GET_STATUS, 16'h0000, 16'h0001), 1, 8'h00, 8'h00);
  endtask

  task automatic test_stall_and_timeout();
    stall_request(make_setup(8'h80, 8'd6, 16'h0100, 16'h0012));
    // Vendor request type
    stall_request(make_setup(8'h40, 8'd0, 16'h0000, 16'h0002));
    open_cycle();
    send_setup(make_setup(8'h80, REQ_GET_STATUS, 16'h0000, 16'h0002));
    send_hsk(HSK_SENT);
    next_cycle();
    check_bit("tx_o.valid with reply pending", tx.valid, 1'b1);
    send_hsk(HSK_TIMEOUT);
    check_bit("select_o after data timeout", select, 1'b0);
    check_bit("finish_o after data timeout", finish, 1'b0);
    next_cycle();
    check_bit("tx_o.valid after data timeout", tx.valid, 1'b0);
    // Back in idle, a new cycle runs normally
    run_in_request(make_setup(8'h80, REQ_GET_CONFIGURATION, 16'h0000, 16'h0001), 1,
                   exp_config, 8'h00);
  endtask

  initial begin
    seed       = 76;
    checks     = 0;
    errors     = 0;
    exp_addr   = 7'h00;
    exp_config = 8'd0;
    reset      = 1'b1;
    tok_recv   = 1'b0;
    tok.addr   = 7'h00;
    tok.endp   = 4'h0;
    tok.pid    = PID_OUT;
    rx.valid   = 1'b0;
    rx.keep    = 1'b0;
    rx.last    = 1'b0;
    rx.pid     = PID_DATA0;
    rx.data    = 8'h00;
    hsk_sent   = 1'b0;
    hsk_recv   = 1'b0;
    timeout    = 1'b0;
    tx_ready   = 1'b0;
    repeat (8) next_cycle();
    reset = 1'b0;
    next_cycle();

    test_reset_state();
    test_set_address();
    test_set_config();
    test_get_replies();
    test_stall_and_timeout();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Run length bound, scaled by the number of tests
  initial begin
    #(NUM_TESTS * 400 * CLK_PERIOD);
    $display("Watchdog expired: tests did not complete within %0d cycles", NUM_TESTS * 400);
    $display("%0d checks, %0d errors", checks, errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* vlog.f */
hw/usb_pkg.sv
hw/ctrl_pkg.sv
hw/ctrl_stage_fsm.sv
hw/ctrl_req_decode.sv
hw/ctrl_req_execute.sv
hw/ctrl_req_result.sv
hw/ctrl_endpoint0.sv
test/ctrl_endpoint0_tb.sv
